// ==== list.f ====
rtl/noc_ep_pkg.sv
rtl/flit_injector.sv
rtl/vc_flit_buffer.sv
rtl/min_prio_ejector.sv
rtl/noc_ep_top.sv
verif/noc_ep_checker.sv
verif/noc_ep_tb.sv

// ==== Bender.yml ====
package:
  name: noc_ep

sources:
  - rtl/noc_ep_pkg.sv
  - rtl/flit_injector.sv
  - rtl/vc_flit_buffer.sv
  - rtl/min_prio_ejector.sv
  - rtl/noc_ep_top.sv
  - target: simulation
    files:
      - verif/noc_ep_checker.sv
      - verif/noc_ep_tb.sv

// ==== verif/noc_ep_tb.sv ====
`default_nettype none

module noc_ep_tb;
    import noc_ep_pkg::*;

    logic              clk;
    logic              rst_n_i;
    logic              in_valid_i;
    logic [VC_W-1:0]   in_vc_i;
    logic [PRIO_W-1:0] in_prio_i;
    logic [DATA_W-1:0] in_data_i;
    logic              ej_ready_i;
    logic              out_valid_o;
    logic [VC_W-1:0]   out_vc_o;
    logic [PRIO_W-1:0] out_prio_o;
    logic [DATA_W-1:0] out_data_o;
    logic [DROP_W-1:0] drop_cnt_o;
    logic [DROP_W-1:0] drop_base;
    logic [31:0]       rng;
    logic              model_empty;
    int                sent_cnt;
    int                tb_errs;
    int                chk_errs;
    int                out_cnt;
    int                n;

    noc_ep_top dut (
        .clk(clk), .rst_n_i(rst_n_i), .in_valid_i(in_valid_i), .in_vc_i(in_vc_i),
        .in_prio_i(in_prio_i), .in_data_i(in_data_i), .ej_ready_i(ej_ready_i),
        .out_valid_o(out_valid_o), .out_vc_o(out_vc_o), .out_prio_o(out_prio_o),
        .out_data_o(out_data_o), .drop_cnt_o(drop_cnt_o)
    );

    noc_ep_checker u_checker (
        .clk(clk), .rst_n_i(rst_n_i), .in_valid_i(in_valid_i), .in_vc_i(in_vc_i),
        .in_prio_i(in_prio_i), .in_data_i(in_data_i), .ej_ready_i(ej_ready_i),
        .out_valid_i(out_valid_o), .out_vc_i(out_vc_o), .out_prio_i(out_prio_o),
        .out_data_i(out_data_o), .drop_cnt_i(drop_cnt_o),
        .err_cnt_o(chk_errs), .out_cnt_o(out_cnt), .model_empty_o(model_empty)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    task automatic send_flit(input logic [VC_W-1:0] vc, input logic [PRIO_W-1:0] prio,
                             input logic [DATA_W-1:0] data);
        @(posedge clk);
        in_valid_i <= 1'b1;
        in_vc_i    <= vc;
        in_prio_i  <= prio;
        in_data_i  <= data;
        sent_cnt++;
    endtask

    task automatic set_levels(input logic valid, input logic ready);
        @(posedge clk);
        in_valid_i <= valid;
        ej_ready_i <= ready;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!model_empty && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!model_empty) begin
            $display("Timeout: the queues did not drain within %0d cycles", limit);
            tb_errs++;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s: expected %0d, got %0d", $time, name, exp, got);
            tb_errs++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_vc_i    = '0;
        in_prio_i  = '0;
        in_data_i  = '0;
        ej_ready_i = 1'b0;
        rng        = 32'd14559;
        sent_cnt   = 0;
        tb_errs    = 0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;

        // quiet after reset
        repeat (8) begin
            @(negedge clk);
            check_value("out_valid_o", 32'(out_valid_o), 32'd0);
            check_value("drop_cnt_o", 32'(drop_cnt_o), 32'd0);
        end

        drop_base = drop_cnt_o;
        for (int i = 0; i < 6; i++) begin
            send_flit(VC_W'(1), PRIO_W'(i), DATA_W'(16'h1a00 + i));   // two more than depth
        end
        set_levels(1'b0, 1'b0);
        n = 0;
        while (32'(drop_cnt_o - drop_base) < 2 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (32'(drop_cnt_o - drop_base) < 2) begin
            $display("Timeout: the drop counter did not rise by two");
            tb_errs++;
        end
        repeat (4) @(negedge clk);
        check_value("drop_cnt_o", 32'(drop_cnt_o), 32'(drop_base) + 32'd2);
        set_levels(1'b0, 1'b1);
        wait_drain(40);

        // fill every VC while the sink stalls
        set_levels(1'b0, 1'b0);
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            for (int v = 0; v < VC_NUM; v++) begin
                rng = xorshift32(rng);
                send_flit(VC_W'(v), rng[2:0], rng[31:16]);
            end
        end
        set_levels(1'b0, 1'b0);
        set_levels(1'b0, 1'b1);
        wait_drain(60);

        repeat (400) begin
            rng = xorshift32(rng);
            @(posedge clk);
            in_valid_i <= rng[0];
            in_vc_i    <= rng[2:1];
            in_prio_i  <= rng[5:3];
            in_data_i  <= rng[21:6];
            ej_ready_i <= rng[24];
            if (rng[0]) begin
                sent_cnt++;
            end
        end
        set_levels(1'b0, 1'b1);
        wait_drain(100);
        check_value("out_cnt+drop_cnt_o", 32'(out_cnt) + 32'(drop_cnt_o), 32'(sent_cnt));

        $display("Errors: checker %0d, testbench %0d", chk_errs, tb_errs);
        if (chk_errs == 0 && tb_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/noc_ep_checker.sv ====
`default_nettype none

module noc_ep_checker (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          in_valid_i,
    input  logic [noc_ep_pkg::VC_W-1:0]   in_vc_i,
    input  logic [noc_ep_pkg::PRIO_W-1:0] in_prio_i,
    input  logic [noc_ep_pkg::DATA_W-1:0] in_data_i,
    input  logic                          ej_ready_i,
    input  logic                          out_valid_i,
    input  logic [noc_ep_pkg::VC_W-1:0]   out_vc_i,
    input  logic [noc_ep_pkg::PRIO_W-1:0] out_prio_i,
    input  logic [noc_ep_pkg::DATA_W-1:0] out_data_i,
    input  logic [noc_ep_pkg::DROP_W-1:0] drop_cnt_i,
    output int                            err_cnt_o,
    output int                            out_cnt_o,
    output logic                          model_empty_o
);
    import noc_ep_pkg::*;

    logic [PRIO_W-1:0] m_prio [VC_NUM][FIFO_DEPTH];    // index 0 is the head
    logic [DATA_W-1:0] m_data [VC_NUM][FIFO_DEPTH];
    int                m_cnt [VC_NUM];
    logic              pend_valid;                     // write registered, lands next edge
    int                pend_vc;
    logic [PRIO_W-1:0] pend_prio;
    logic [DATA_W-1:0] pend_data;
    logic              exp_valid;
    int                exp_vc;
    logic [PRIO_W-1:0] exp_prio;
    logic [DATA_W-1:0] exp_data;
    logic [DROP_W-1:0] exp_drop;
    logic              prev_ready;
    logic              seen_rst;
    logic              full;
    int                win;
    int                total;

    initial begin
        err_cnt_o     = 0;
        out_cnt_o     = 0;
        seen_rst      = 1'b0;
        model_empty_o = 1'b0;
    end

    // smallest head priority first, lowest VC on a tie
    function automatic int pick_vc();
        int best;
        best = -1;
        for (int i = 0; i < VC_NUM; i++) begin
            if (m_cnt[i] > 0 && (best < 0 || m_prio[i][0] < m_prio[best][0])) begin
                best = i;
            end
        end
        return best;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s: expected 0x%0h, got 0x%0h", $time, name, exp, got);
            err_cnt_o++;
        end
    endtask

    always @(posedge clk) begin
        if (seen_rst) begin
            check_field("out_valid_o", 32'(out_valid_i), 32'(exp_valid));
            if (out_valid_i === 1'b1 && exp_valid) begin
                check_field("out_vc_o", 32'(out_vc_i), 32'(exp_vc));
                check_field("out_prio_o", 32'(out_prio_i), 32'(exp_prio));
                check_field("out_data_o", 32'(out_data_i), 32'(exp_data));
            end
            if (out_valid_i === 1'b1 && !prev_ready) begin
                $display("Error t=%0t: a flit came out after an edge with ej_ready_i low", $time);
                err_cnt_o++;
            end
            check_field("drop_cnt_o", 32'(drop_cnt_i), 32'(exp_drop));
            if (out_valid_i === 1'b1) begin
                out_cnt_o++;
            end
        end
        prev_ready = ej_ready_i;
        if (!rst_n_i) begin
            for (int i = 0; i < VC_NUM; i++) begin
                m_cnt[i] = 0;
            end
            pend_valid = 1'b0;
            exp_valid  = 1'b0;
            exp_drop   = '0;
            out_cnt_o  = 0;
            seen_rst   = 1'b1;
        end else begin
            // full rule sees occupancy before this edge
            full = in_valid_i && ((m_cnt[in_vc_i] == FIFO_DEPTH) ||
                   (m_cnt[in_vc_i] == FIFO_DEPTH - 1 && pend_valid && pend_vc == in_vc_i));
            exp_valid = 1'b0;
            win = ej_ready_i ? pick_vc() : -1;
            if (win >= 0) begin
                exp_valid = 1'b1;
                exp_vc    = win;
                exp_prio  = m_prio[win][0];
                exp_data  = m_data[win][0];
                for (int k = 0; k < FIFO_DEPTH - 1; k++) begin
                    m_prio[win][k] = m_prio[win][k+1];
                    m_data[win][k] = m_data[win][k+1];
                end
                m_cnt[win]--;
            end
            if (pend_valid) begin
                m_prio[pend_vc][m_cnt[pend_vc]] = pend_prio;
                m_data[pend_vc][m_cnt[pend_vc]] = pend_data;
                m_cnt[pend_vc]++;
            end
            pend_valid = in_valid_i && !full;
            pend_vc    = in_vc_i;
            pend_prio  = in_prio_i;
            pend_data  = in_data_i;
            if (full && exp_drop != '1) begin
                exp_drop = exp_drop + 1'b1;
            end
        end
        total = 0;
        for (int i = 0; i < VC_NUM; i++) begin
            total += m_cnt[i];
        end
        model_empty_o = (total == 0) && !pend_valid && !exp_valid;
    end

endmodule

`default_nettype wire

// ==== rtl/noc_ep_top.sv ====
`default_nettype none

module noc_ep_top (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic                              in_valid_i,
    input  logic [noc_ep_pkg::VC_W-1:0]       in_vc_i,
    input  logic [noc_ep_pkg::PRIO_W-1:0]     in_prio_i,
    input  logic [noc_ep_pkg::DATA_W-1:0]     in_data_i,
    input  logic                              ej_ready_i,
    output logic                              out_valid_o,
    output logic [noc_ep_pkg::VC_W-1:0]       out_vc_o,
    output logic [noc_ep_pkg::PRIO_W-1:0]     out_prio_o,
    output logic [noc_ep_pkg::DATA_W-1:0]     out_data_o,
    output logic [noc_ep_pkg::DROP_W-1:0]     drop_cnt_o
);
    import noc_ep_pkg::*;

    logic [VC_NUM-1:0]        wr_sel;
    logic [PRIO_W-1:0]        wr_prio;
    logic [DATA_W-1:0]        wr_data;
    logic [VC_NUM*CNT_W-1:0]  occ;           // flattened per-VC counts
    logic [VC_NUM-1:0]        nonempty;
    logic [VC_NUM*PRIO_W-1:0] head_prio;
    logic [VC_NUM*DATA_W-1:0] head_data;
    logic [VC_NUM-1:0]        pop_sel;

    flit_injector u_injector (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_vc_i    (in_vc_i),
        .in_prio_i  (in_prio_i),
        .in_data_i  (in_data_i),
        .occ_i      (occ),
        .wr_sel_o   (wr_sel),
        .wr_prio_o  (wr_prio),
        .wr_data_o  (wr_data),
        .drop_cnt_o (drop_cnt_o)
    );

    vc_flit_buffer u_buffer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wr_sel_i    (wr_sel),
        .wr_prio_i   (wr_prio),
        .wr_data_i   (wr_data),
        .pop_sel_i   (pop_sel),
        .occ_o       (occ),
        .nonempty_o  (nonempty),
        .head_prio_o (head_prio),
        .head_data_o (head_data)
    );

    min_prio_ejector u_ejector (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ej_ready_i  (ej_ready_i),
        .nonempty_i  (nonempty),
        .head_prio_i (head_prio),
        .head_data_i (head_data),
        .pop_sel_o   (pop_sel),
        .out_valid_o (out_valid_o),
        .out_vc_o    (out_vc_o),
        .out_prio_o  (out_prio_o),
        .out_data_o  (out_data_o)
    );

endmodule

`default_nettype wire

// ==== rtl/min_prio_ejector.sv ====
`default_nettype none

module min_prio_ejector (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  logic                                              ej_ready_i,
    input  logic [noc_ep_pkg::VC_NUM-1:0]                     nonempty_i,
    input  logic [noc_ep_pkg::VC_NUM*noc_ep_pkg::PRIO_W-1:0]  head_prio_i,
    input  logic [noc_ep_pkg::VC_NUM*noc_ep_pkg::DATA_W-1:0]  head_data_i,
    output logic [noc_ep_pkg::VC_NUM-1:0]                     pop_sel_o,
    output logic                                              out_valid_o,
    output logic [noc_ep_pkg::VC_W-1:0]                       out_vc_o,
    output logic [noc_ep_pkg::PRIO_W-1:0]                     out_prio_o,
    output logic [noc_ep_pkg::DATA_W-1:0]                     out_data_o
);
    import noc_ep_pkg::*;

    logic [PRIO_W:0]   key [VC_NUM];                // one extra bit ranks empty VCs last
    logic [VC_NUM-1:0] le_mat [VC_NUM];
    logic [VC_NUM-1:0] win;
    logic [VC_W-1:0]   win_vc;
    logic [PRIO_W-1:0] win_prio;
    logic [DATA_W-1:0] win_data;
    logic              do_pop;
    ej_state_e         state_d;
    ej_state_e         state_q;

    // empty VC gets max priority plus one
    always_comb begin
        for (int i = 0; i < VC_NUM; i++) begin
            key[i] = nonempty_i[i] ? {1'b0, head_prio_i[i*PRIO_W +: PRIO_W]}
                                   : {1'b1, {PRIO_W{1'b0}}};
        end
    end

    // all-pairs compare, <= toward higher index so the lowest index wins a tie
    always_comb begin
        for (int i = 0; i < VC_NUM; i++) begin
            for (int j = 0; j < VC_NUM; j++) begin
                if (i == j) begin
                    le_mat[i][j] = 1'b1;
                end else if (i < j) begin
                    le_mat[i][j] = (key[i] <= key[j]);
                end else begin
                    le_mat[i][j] = (key[i] < key[j]);
                end
            end
            win[i] = &le_mat[i];
        end
    end

    // one-hot mux, OR of masked entries
    always_comb begin
        win_vc   = '0;
        win_prio = '0;
        win_data = '0;
        for (int i = 0; i < VC_NUM; i++) begin
            win_vc   |= VC_W'(i) & {VC_W{win[i]}};
            win_prio |= head_prio_i[i*PRIO_W +: PRIO_W] & {PRIO_W{win[i]}};
            win_data |= head_data_i[i*DATA_W +: DATA_W] & {DATA_W{win[i]}};
        end
    end

    assign do_pop    = ej_ready_i && (nonempty_i != '0);
    assign pop_sel_o = win & {VC_NUM{do_pop}};
    assign state_d   = do_pop ? EJ_DRAIN : EJ_IDLE;

    // state holds whether the last edge drained a flit
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= EJ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign out_valid_o = (state_q == EJ_DRAIN);

    always_ff @(posedge clk) begin
        if (do_pop) begin
            out_vc_o   <= win_vc;
            out_prio_o <= win_prio;
            out_data_o <= win_data;
        end
    end

    a_pop_onehot: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (ej_ready_i && (nonempty_i != '0)) |-> $onehot(pop_sel_o)
    );

endmodule

`default_nettype wire

// ==== rtl/vc_flit_buffer.sv ====
`default_nettype none

module vc_flit_buffer (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  logic [noc_ep_pkg::VC_NUM-1:0]                     wr_sel_i,
    input  logic [noc_ep_pkg::PRIO_W-1:0]                     wr_prio_i,
    input  logic [noc_ep_pkg::DATA_W-1:0]                     wr_data_i,
    input  logic [noc_ep_pkg::VC_NUM-1:0]                     pop_sel_i,
    output logic [noc_ep_pkg::VC_NUM*noc_ep_pkg::CNT_W-1:0]   occ_o,
    output logic [noc_ep_pkg::VC_NUM-1:0]                     nonempty_o,
    output logic [noc_ep_pkg::VC_NUM*noc_ep_pkg::PRIO_W-1:0]  head_prio_o,
    output logic [noc_ep_pkg::VC_NUM*noc_ep_pkg::DATA_W-1:0]  head_data_o
);
    import noc_ep_pkg::*;

    for (genvar v = 0; v < VC_NUM; v++) begin : g_vc
        logic [PTR_W-1:0]  wr_ptr;
        logic [PTR_W-1:0]  rd_ptr;
        logic [CNT_W-1:0]  cnt;
        logic [PRIO_W-1:0] prio_mem [FIFO_DEPTH];
        logic [DATA_W-1:0] data_mem [FIFO_DEPTH];

        // storage, written at the tail
        always_ff @(posedge clk) begin
            if (wr_sel_i[v]) begin
                prio_mem[wr_ptr] <= wr_prio_i;
                data_mem[wr_ptr] <= wr_data_i;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n_i) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                cnt    <= '0;
            end else begin
                if (wr_sel_i[v]) begin
                    wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop_sel_i[v]) begin
                    rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({wr_sel_i[v], pop_sel_i[v]})
                    2'b10:   cnt <= cnt + 1'b1;
                    2'b01:   cnt <= cnt - 1'b1;
                    default: cnt <= cnt;            // idle, or write and pop together
                endcase
            end
        end

        assign occ_o[v*CNT_W +: CNT_W]         = cnt;
        assign nonempty_o[v]                   = (cnt != '0);
        assign head_prio_o[v*PRIO_W +: PRIO_W] = prio_mem[rd_ptr];
        assign head_data_o[v*DATA_W +: DATA_W] = data_mem[rd_ptr];

        // injector full rule must keep writes off a full queue
        a_no_wr_full: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            wr_sel_i[v] |-> (cnt != CNT_W'(FIFO_DEPTH))
        );

        // ejector only pops what it saw as non-empty
        a_no_pop_empty: assert property (
            @(posedge clk) disable iff (!rst_n_i)
            pop_sel_i[v] |-> (cnt != '0)
        );
    end

endmodule

`default_nettype wire

// ==== rtl/flit_injector.sv ====
`default_nettype none

module flit_injector (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  logic                                              in_valid_i,
    input  logic [noc_ep_pkg::VC_W-1:0]                       in_vc_i,
    input  logic [noc_ep_pkg::PRIO_W-1:0]                     in_prio_i,
    input  logic [noc_ep_pkg::DATA_W-1:0]                     in_data_i,
    input  logic [noc_ep_pkg::VC_NUM*noc_ep_pkg::CNT_W-1:0]   occ_i,
    output logic [noc_ep_pkg::VC_NUM-1:0]                     wr_sel_o,
    output logic [noc_ep_pkg::PRIO_W-1:0]                     wr_prio_o,
    output logic [noc_ep_pkg::DATA_W-1:0]                     wr_data_o,
    output logic [noc_ep_pkg::DROP_W-1:0]                     drop_cnt_o
);
    import noc_ep_pkg::*;

    logic [VC_NUM-1:0] vc_onehot;
    logic [CNT_W-1:0]  sel_occ;
    logic              wr_pending;
    logic              vc_full;

    // binary VC to one-hot select
    always_comb begin
        for (int i = 0; i < VC_NUM; i++) begin
            vc_onehot[i] = (in_vc_i == VC_W'(i));
        end
    end

    assign sel_occ    = occ_i[in_vc_i*CNT_W +: CNT_W];
    assign wr_pending = |(wr_sel_o & vc_onehot);    // registered write not yet landed

    // a pending write to the same VC still occupies one slot
    assign vc_full = (sel_occ == CNT_W'(FIFO_DEPTH)) ||
                     ((sel_occ == CNT_W'(FIFO_DEPTH - 1)) && wr_pending);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_sel_o   <= '0;
            drop_cnt_o <= '0;
        end else begin
            wr_sel_o <= vc_onehot & {VC_NUM{in_valid_i && !vc_full}};
            if (in_valid_i && vc_full && (drop_cnt_o != {DROP_W{1'b1}})) begin
                drop_cnt_o <= drop_cnt_o + 1'b1;    // saturates at all ones
            end
        end
    end

    // flit payload, qualified by wr_sel_o
    always_ff @(posedge clk) begin
        if (in_valid_i) begin
            wr_prio_o <= in_prio_i;
            wr_data_o <= in_data_i;
        end
    end

    // at most one VC written per edge
    a_wr_sel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $onehot0(wr_sel_o)
    );

endmodule

`default_nettype wire

// ==== rtl/noc_ep_pkg.sv ====
`default_nettype none

package noc_ep_pkg;

    // virtual channel layout
    localparam int VC_NUM     = 4;
    localparam int VC_W       = 2;                 // index of one of VC_NUM channels

    // per-VC queue geometry
    localparam int FIFO_DEPTH = 4;                 // flits per VC queue
    localparam int PTR_W      = 2;                 // addresses FIFO_DEPTH slots
    localparam int CNT_W      = 3;                 // holds 0 .. FIFO_DEPTH

    // flit fields
    localparam int PRIO_W     = 3;                 // smaller value is more urgent
    localparam int DATA_W     = 16;

    // statistics
    localparam int DROP_W     = 16;                // saturating drop counter

    // ejector state
    typedef enum logic {
        EJ_IDLE  = 1'b0,                           // nothing buffered
        EJ_DRAIN = 1'b1                            // a VC is non-empty and pops are possible
    } ej_state_e;

endpackage

`default_nettype wire
